/* rvCore.f */
+incdir+.
rvCorePkg.sv
ctrlIf.sv
instrDecoder.sv
regFile.sv
alu.sv
mainFsm.sv
datapath.sv
rvCore.sv
tbRvCore.sv

/* Makefile */
# Verilator flow for the rvCore testbench

LOG := sim.log

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		--top-module tbRvCore -Mdir obj_dir -f rvCore.f

run: compile
	./obj_dir/VtbRvCore | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

/* tbRvCore.sv */
// rvCore testbench
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module tbRvCore;

	localparam int MEM_WORDS   = 1 << `MEM_AW;
	localparam int WATCHDOG_NS = 6 * 40 * 5 * 100; // tests x instructions x cycles x period

	logic             clk = 1'b0;
	logic             rstN;
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] memWData;
	logic             memWrite;
	logic [`XLEN-1:0] memRData;

	logic [`XLEN-1:0] mem     [MEM_WORDS];
	logic [`XLEN-1:0] image   [MEM_WORDS]; // program copied into mem during reset
	logic [`XLEN-1:0] stAddr  [$];
	logic [`XLEN-1:0] stData  [$];
	logic [`XLEN-1:0] expAddr [$];
	logic [`XLEN-1:0] expData [$];
	logic [31:0]      lfsr;
	int               progIdx;
	int               stIdx;

	rvCore u_dut (
		.i_clk     (clk),
		.i_rst_n   (rstN),
		.o_memAddr (memAddr),
		.o_memWData(memWData),
		.o_memWrite(memWrite),
		.i_memRData(memRData)
	);

	always #50 clk = ~clk;

	assign memRData = rstN ? mem[memAddr[`MEM_AW+1:2]] : '0;

	always @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= image[i];
		end
		else if (memWrite)
			mem[memAddr[`MEM_AW+1:2]] <= memWData;
	end

	// store monitor sampled mid-cycle
	always @(negedge clk)
	begin
		if (!rstN)
		begin
			stAddr.delete();
			stData.delete();
		end
		else if (memWrite)
		begin
			stAddr.push_back(memAddr);
			stData.push_back(memWData);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		failRun("Timeout: the tests did not finish before the watchdog expired");
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(
		input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp,
		input string            what
	);
		if (got !== exp)
			failRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkCtrl(input logic got, input logic exp, input string what);
		if (got !== exp)
			failRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		int          k;
		val = '0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// RV32I reference results by funct3
	function automatic logic [31:0] refAlu(
		input logic [2:0]  f3,
		input logic        sub,
		input logic [31:0] a,
		input logic [31:0] b
	);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b100:  return a ^ b;
			3'b101:  return a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] encR(
		input logic [6:0] f7,
		input logic [4:0] rs2,
		input logic [4:0] rs1,
		input logic [2:0] f3,
		input logic [4:0] rd
	);
		return {f7, rs2, rs1, f3, rd, `OP_REG};
	endfunction

	function automatic logic [31:0] encI(
		input logic [6:0]  op,
		input logic [11:0] imm,
		input logic [4:0]  rs1,
		input logic [2:0]  f3,
		input logic [4:0]  rd
	);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(
		input logic [11:0] imm,
		input logic [4:0]  rs2,
		input logic [4:0]  rs1
	);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
	endfunction

	function automatic logic [31:0] encB(
		input logic [12:0] imm,
		input logic [4:0]  rs2,
		input logic [4:0]  rs1
	);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `OP_LUI};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	task automatic startProgram();
		int i;
		for (i = 0; i < MEM_WORDS; i++)
			image[i] = 32'hbad0_0000 | 32'(i); // unused words carry their index
		progIdx = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic emit(input logic [31:0] word);
		image[progIdx] = word;
		progIdx++;
	endtask

	task automatic finishProgram();
		emit(encJ(21'd0, 5'd0)); // jump to self
	endtask

	// lui plus addi with the upper part rounded for the sign of the low part
	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		emit(encU(upper[31:12], rd));
		emit(encI(`OP_IMM, value[11:0], rd, 3'b000, rd));
	endtask

	task automatic storeExpect(input logic [4:0] rs, input logic [31:0] addr,
		input logic [31:0] value);
		emit(encS(addr[11:0], rs, 5'd0));
		expAddr.push_back(addr);
		expData.push_back(value);
	endtask

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			checkCtrl(memWrite, 1'b0, "memWrite during reset");
		end
		@(posedge clk);
		rstN <= 1'b1;
		stIdx = 0;
	endtask

	task automatic checkStores(input string test);
		int n;
		for (n = 0; n < expAddr.size(); n++)
		begin
			while (stAddr.size() <= stIdx)
				@(negedge clk);
			checkWord(stAddr[stIdx], expAddr[n], {test, " store address"});
			checkWord(stData[stIdx], expData[n], {test, " store data"});
			stIdx++;
		end
	endtask

	task automatic testReset();
		startProgram();
		finishProgram();
		applyReset();
		@(negedge clk);
		checkWord(memAddr, 32'h0, "first fetch address");
		checkCtrl(memWrite, 1'b0, "memWrite after reset");
	endtask

	task automatic testArith();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] bImm;
		logic [31:0] addr;
		logic [11:0] imm;
		int          f;
		a    = randBits(32);
		b    = randBits(32);
		addr = 32'h200;
		startProgram();
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		emit(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd3)); // sub
		storeExpect(5'd3, addr, refAlu(3'b000, 1'b1, a, b));
		addr += 32'd4;
		for (f = 0; f < 8; f++)
		begin
			if (f != 3) // sltu left out
			begin
				emit(encR(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
				storeExpect(5'd3, addr, refAlu(3'(f), 1'b0, a, b));
				if (f == 1 || f == 5)
					imm = {7'b0, 5'(randBits(5))};
				else
					imm = 12'(randBits(12));
				bImm = {{20{imm[11]}}, imm};
				emit(encI(`OP_IMM, imm, 5'd1, 3'(f), 5'd4));
				storeExpect(5'd4, addr + 32'd4, refAlu(3'(f), 1'b0, a, bImm));
				addr += 32'd8;
			end
		end
		finishProgram();
		applyReset();
		checkStores("arith");
	endtask

	task automatic testMemory();
		logic [31:0] w;
		logic [31:0] off;
		w   = randBits(32);
		off = 32'h200 + (randBits(6) << 2);
		startProgram();
		loadConst(5'd5, w);
		loadConst(5'd7, off + 32'd8);
		storeExpect(5'd5, off, w);
		emit(encI(`OP_LOAD, 12'hff8, 5'd7, 3'b010, 5'd6)); // base minus eight
		storeExpect(5'd6, 32'h300, w);
		finishProgram();
		applyReset();
		checkStores("memory");
	endtask

	task automatic testBranch();
		logic [31:0] r;
		r = randBits(32);
		startProgram();
		loadConst(5'd1, r);
		loadConst(5'd2, r);
		loadConst(5'd3, r ^ 32'd1);
		loadConst(5'd10, 32'd1);  // taken marker
		loadConst(5'd11, 32'd2);  // fall-through marker
		emit(encB(13'd8, 5'd2, 5'd1));
		emit(encS(12'h200, 5'd11, 5'd0));
		storeExpect(5'd10, 32'h204, 32'd1);
		emit(encB(13'd8, 5'd3, 5'd1));
		storeExpect(5'd11, 32'h208, 32'd2);
		storeExpect(5'd10, 32'h20c, 32'd1);
		finishProgram();
		applyReset();
		checkStores("branch");
	endtask

	task automatic testJumps();
		logic [31:0] target;
		int          s1;
		int          s2;
		int          k;
		s1     = 1 + int'(randBits(2));
		s2     = 1 + int'(randBits(2));
		target = 32'((5 + s1 + s2) * 4);
		startProgram();
		loadConst(5'd5, target + 32'd12);
		emit(encJ(21'((1 + s1) * 4), 5'd1)); // jal at byte 8
		for (k = 0; k < s1; k++)
			emit(encS(12'h3f0, 5'd0, 5'd0)); // only reached on a wrong jump
		storeExpect(5'd1, 32'h200, 32'd12);
		emit(encI(`OP_JALR, 12'hff4, 5'd5, 3'b000, 5'd2));
		for (k = 0; k < s2; k++)
			emit(encS(12'h3f0, 5'd0, 5'd0));
		storeExpect(5'd2, 32'h204, 32'((5 + s1) * 4));
		finishProgram();
		applyReset();
		checkStores("jumps");
	endtask

	task automatic testX0();
		logic [31:0] r;
		r = randBits(32) | 32'd1;
		startProgram();
		loadConst(5'd1, r);
		emit(encU(20'(randBits(20)), 5'd0));
		emit(encI(`OP_IMM, 12'(randBits(12)), 5'd1, 3'b000, 5'd0));
		emit(encR(7'h00, 5'd1, 5'd1, 3'b110, 5'd0));
		storeExpect(5'd0, 32'h200, 32'h0);
		storeExpect(5'd1, 32'h204, r);
		finishProgram();
		applyReset();
		checkStores("x0");
	endtask

	initial
	begin
		rstN    = 1'b0;
		lfsr    = 32'h3fd5;
		stIdx   = 0;
		progIdx = 0;
		testReset();
		testArith();
		testMemory();
		testBranch();
		testJumps();
		testX0();
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* rvCore.sv */
// Multicycle RV32I core
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module rvCore (
	input  logic             i_clk,
	input  logic             i_rst_n,
	output logic [`XLEN-1:0] o_memAddr,
	output logic [`XLEN-1:0] o_memWData,
	output logic             o_memWrite,
	input  logic [`XLEN-1:0] i_memRData
);

	ctrlIf ctrl ();

	mainFsm u_mainFsm (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.ctrl   (ctrl.ctl)
	);

	datapath u_datapath (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.ctrl      (ctrl.dp),
		.o_memAddr (o_memAddr),
		.o_memWData(o_memWData),
		.i_memRData(i_memRData)
	);

	assign o_memWrite = ctrl.memWrite; // single cycle, in the store state

endmodule

/* datapath.sv */
// Multicycle datapath
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module datapath (
	input  logic             i_clk,
	input  logic             i_rst_n,
	ctrlIf.dp                ctrl,
	output logic [`XLEN-1:0] o_memAddr,
	output logic [`XLEN-1:0] o_memWData,
	input  logic [`XLEN-1:0] i_memRData
);
	import rvCorePkg::*;

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] oldPc;
	instrT            instrReg;
	logic [`XLEN-1:0] dataReg;
	logic [`XLEN-1:0] aReg;
	logic [`XLEN-1:0] bReg;
	logic [`XLEN-1:0] aluOut;
	logic [`XLEN-1:0] immExt;
	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] aluY;
	logic [`XLEN-1:0] result;
	logic [`XLEN-1:0] rData1;
	logic [`XLEN-1:0] rData2;
	logic [4:0]       rs1Idx;

	assign ctrl.instr = instrReg;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			pc       <= `RESET_PC;
			instrReg <= '0;
		end
		else
		begin
			if (ctrl.pcWrite)
				pc <= result;
			if (ctrl.irWrite)
				instrReg <= i_memRData;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (ctrl.irWrite)
			oldPc <= pc; // address of the instruction being fetched
		dataReg <= i_memRData;
		aReg    <= rData1;
		bReg    <= rData2;
		aluOut  <= aluY;
	end

	always_comb
	begin
		case (ctrl.immSrc)
			IMM_I: immExt = {{(`XLEN-12){instrReg.i.imm[11]}}, instrReg.i.imm};
			IMM_S: immExt = {{(`XLEN-12){instrReg.s.immHi[6]}}, instrReg.s.immHi,
				instrReg.s.immLo};
			IMM_B: immExt = {{(`XLEN-12){instrReg.b.imm12}}, instrReg.b.imm11,
				instrReg.b.imm10_5, instrReg.b.imm4_1, 1'b0};
			IMM_U: immExt = {instrReg.u.imm, 12'b0};
			IMM_J: immExt = {{(`XLEN-20){instrReg.j.imm20}}, instrReg.j.imm19_12,
				instrReg.j.imm11, instrReg.j.imm10_1, 1'b0};
			default: immExt = '0;
		endcase
	end

	// lui has no rs1 field so x0 is read
	assign rs1Idx = (ctrl.immSrc == IMM_U) ? 5'd0 : instrReg.r.rs1;

	always_comb
	begin
		case (ctrl.aluSrcA)
			SRCA_PC:    srcA = pc;
			SRCA_OLDPC: srcA = oldPc;
			default:    srcA = aReg;
		endcase
		case (ctrl.aluSrcB)
			SRCB_IMM:  srcB = immExt;
			SRCB_FOUR: srcB = `XLEN'(4);
			default:   srcB = bReg;
		endcase
	end

	always_comb
	begin
		case (ctrl.resultSrc)
			RES_DATA: result = dataReg;
			RES_ALU:  result = aluY;
			default:  result = aluOut;
		endcase
	end

	assign o_memAddr  = ctrl.adrSrc ? aluOut : pc;
	assign o_memWData = bReg;

	regFile u_regFile (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rs1   (rs1Idx),
		.i_rs2   (instrReg.r.rs2),
		.i_rd    (instrReg.r.rd),
		.i_we    (ctrl.regWrite),
		.i_wData (result),
		.o_rData1(rData1),
		.o_rData2(rData2)
	);

	alu u_alu (
		.i_a   (srcA),
		.i_b   (srcB),
		.i_ctrl(ctrl.aluCtrl),
		.o_y   (aluY),
		.o_zero(ctrl.zero)
	);

endmodule

/* mainFsm.sv */
// Multicycle control FSM
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module mainFsm (
	input logic i_clk,
	input logic i_rst_n,
	ctrlIf.ctl  ctrl
);
	import rvCorePkg::*;

	stateT      state;
	stateT      nextState;
	aluOpT      aluOp;
	logic       pcUpdate;
	logic       branch;
	logic [6:0] opcode;

	assign opcode       = ctrl.instr.r.opcode;
	assign ctrl.pcWrite = pcUpdate | (branch & ctrl.zero);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			state <= FETCH;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = FETCH;
		case (state)
			FETCH:     nextState = DECODE;
			DECODE:
			begin
				case (opcode)
					`OP_LOAD, `OP_STORE: nextState = MEMADR;
					`OP_REG:             nextState = EXECUTE_R;
					`OP_IMM, `OP_JALR:   nextState = EXECUTE_I;
					`OP_JAL:             nextState = JAL;
					`OP_BRANCH:          nextState = BEQ;
					`OP_LUI:             nextState = ALUWB;
					default:             nextState = FETCH; // unsupported, skip it
				endcase
			end
			MEMADR:    nextState = (opcode == `OP_LOAD) ? MEMREAD : MEMWRITE;
			EXECUTE_R: nextState = ALUWB;
			EXECUTE_I: nextState = (opcode == `OP_JALR) ? JAL : ALUWB;
			JAL:       nextState = ALUWB;
			MEMREAD:   nextState = MEMWB;
			default:   nextState = FETCH; // beq, store and write-backs end here
		endcase
	end

	always_comb
	begin
		ctrl.adrSrc    = 1'b0;
		ctrl.irWrite   = 1'b0;
		ctrl.regWrite  = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.resultSrc = RES_ALUOUT;
		ctrl.aluSrcA   = SRCA_REG;
		ctrl.aluSrcB   = SRCB_REG;
		aluOp          = ADD_OP;
		pcUpdate       = 1'b0;
		branch         = 1'b0;
		case (state)
			FETCH:
			begin
				ctrl.irWrite   = 1'b1;
				ctrl.aluSrcA   = SRCA_PC;
				ctrl.aluSrcB   = SRCB_FOUR;
				ctrl.resultSrc = RES_ALU; // pc + 4 straight to pc
				pcUpdate       = 1'b1;
			end
			DECODE:
			begin
				ctrl.aluSrcA = SRCA_OLDPC; // branch and jal target into aluOut
				ctrl.aluSrcB = SRCB_IMM;
			end
			MEMADR:    ctrl.aluSrcB = SRCB_IMM;
			EXECUTE_R: aluOp = FUNC_OP;
			EXECUTE_I:
			begin
				ctrl.aluSrcB = SRCB_IMM;
				aluOp        = (opcode == `OP_JALR) ? ADD_OP : FUNC_OP;
			end
			JAL:
			begin
				ctrl.aluSrcA = SRCA_OLDPC; // link address
				ctrl.aluSrcB = SRCB_FOUR;
				pcUpdate     = 1'b1;
			end
			BEQ:
			begin
				aluOp  = SUB_OP;
				branch = 1'b1;
			end
			MEMREAD:   ctrl.adrSrc = 1'b1;
			MEMWRITE:
			begin
				ctrl.adrSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			ALUWB:
			begin
				ctrl.regWrite = 1'b1;
				if (opcode == `OP_LUI)
				begin
					ctrl.aluSrcB   = SRCB_IMM; // x0 + upper immediate
					ctrl.resultSrc = RES_ALU;
				end
			end
			MEMWB:
			begin
				ctrl.regWrite  = 1'b1;
				ctrl.resultSrc = RES_DATA;
			end
			default: ;
		endcase
	end

	instrDecoder u_instrDecoder (
		.i_instr  (ctrl.instr),
		.i_aluOp  (aluOp),
		.o_aluCtrl(ctrl.aluCtrl),
		.o_immSrc (ctrl.immSrc)
	);

endmodule

/* alu.sv */
// Integer ALU
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module alu (
	input  logic [`XLEN-1:0]  i_a,
	input  logic [`XLEN-1:0]  i_b,
	input  rvCorePkg::aluCtrlT i_ctrl,
	output logic [`XLEN-1:0]  o_y,
	output logic              o_zero
);
	import rvCorePkg::*;

	logic lessThan;

	assign lessThan = $signed(i_a) < $signed(i_b);

	always_comb
	begin
		case (i_ctrl)
			ALU_ADD: o_y = i_a + i_b;
			ALU_SUB: o_y = i_a - i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_OR:  o_y = i_a | i_b;
			ALU_XOR: o_y = i_a ^ i_b;
			ALU_SLT: o_y = {{(`XLEN-1){1'b0}}, lessThan};
			ALU_SLL: o_y = i_a << i_b[4:0]; // shamt is the low five bits
			ALU_SRL: o_y = i_a >> i_b[4:0];
			default: o_y = '0;
		endcase
	end

	assign o_zero = (o_y == '0);

endmodule

/* regFile.sv */
// Integer register file
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module regFile (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [$clog2(`REG_COUNT)-1:0] i_rs1,
	input  logic [$clog2(`REG_COUNT)-1:0] i_rs2,
	input  logic [$clog2(`REG_COUNT)-1:0] i_rd,
	input  logic                          i_we,
	input  logic [`XLEN-1:0]              i_wData,
	output logic [`XLEN-1:0]              o_rData1,
	output logic [`XLEN-1:0]              o_rData2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (i_we && (i_rd != '0)) // x0 stays zero
			regs[i_rd] <= i_wData;
	end

	assign o_rData1 = regs[i_rs1];
	assign o_rData2 = regs[i_rs2];

endmodule

/* instrDecoder.sv */
// ALU and immediate decode
`timescale 1ns/10ps
`include "rvCore_macros.svh"

module instrDecoder (
	input  rvCorePkg::instrT   i_instr,
	input  rvCorePkg::aluOpT   i_aluOp,
	output rvCorePkg::aluCtrlT o_aluCtrl,
	output rvCorePkg::immSrcT  o_immSrc
);
	import rvCorePkg::*;

	logic subtract;

	// only a register-register op with funct7[5] subtracts
	assign subtract = i_instr.r.opcode[5] & i_instr.r.funct7[5];

	always_comb
	begin
		case (i_aluOp)
			ADD_OP: o_aluCtrl = ALU_ADD;
			SUB_OP: o_aluCtrl = ALU_SUB;
			default:
			begin
				case (i_instr.r.funct3)
					3'b000:  o_aluCtrl = subtract ? ALU_SUB : ALU_ADD;
					3'b001:  o_aluCtrl = ALU_SLL;
					3'b010:  o_aluCtrl = ALU_SLT;
					3'b100:  o_aluCtrl = ALU_XOR;
					3'b101:  o_aluCtrl = ALU_SRL;
					3'b110:  o_aluCtrl = ALU_OR;
					3'b111:  o_aluCtrl = ALU_AND;
					default: o_aluCtrl = ALU_ADD; // sltu not supported
				endcase
			end
		endcase
	end

	always_comb
	begin
		case (i_instr.r.opcode)
			`OP_STORE:  o_immSrc = IMM_S;
			`OP_BRANCH: o_immSrc = IMM_B;
			`OP_LUI:    o_immSrc = IMM_U;
			`OP_JAL:    o_immSrc = IMM_J;
			default:    o_immSrc = IMM_I; // loads, op-imm, jalr
		endcase
	end

endmodule

/* ctrlIf.sv */
// Controller to datapath link
`timescale 1ns/10ps

interface ctrlIf;
	import rvCorePkg::*;

	instrT     instr;    // instruction register contents
	logic      zero;     // alu result is zero
	logic      pcWrite;
	logic      adrSrc;   // 0 pc, 1 aluOut
	logic      irWrite;
	logic      regWrite;
	logic      memWrite;
	resultSrcT resultSrc;
	srcAT      aluSrcA;
	srcBT      aluSrcB;
	aluCtrlT   aluCtrl;
	immSrcT    immSrc;

	modport ctl (
		input  instr, zero,
		output pcWrite, adrSrc, irWrite, regWrite, memWrite,
		output resultSrc, aluSrcA, aluSrcB, aluCtrl, immSrc
	);

	modport dp (
		output instr, zero,
		input  pcWrite, adrSrc, irWrite, regWrite, memWrite,
		input  resultSrc, aluSrcA, aluSrcB, aluCtrl, immSrc
	);

endinterface

/* rvCorePkg.sv */
// RV32I core types
package rvCorePkg;

	typedef enum logic [3:0] {
		FETCH     = 4'd0,
		DECODE    = 4'd1,
		MEMADR    = 4'd2,
		EXECUTE_R = 4'd3,
		EXECUTE_I = 4'd4,
		JAL       = 4'd5,
		BEQ       = 4'd6,
		MEMREAD   = 4'd7,
		MEMWRITE  = 4'd8,
		ALUWB     = 4'd9,
		MEMWB     = 4'd10
	} stateT;

	typedef enum logic [1:0] {ADD_OP = 2'b00, SUB_OP = 2'b01, FUNC_OP = 2'b10} aluOpT;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
	} aluCtrlT;

	typedef enum logic [1:0] {SRCA_PC, SRCA_OLDPC, SRCA_REG} srcAT;
	typedef enum logic [1:0] {SRCB_REG, SRCB_IMM, SRCB_FOUR} srcBT;
	typedef enum logic [1:0] {RES_ALUOUT, RES_DATA, RES_ALU} resultSrcT;
	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSrcT;

	// one instruction word, viewed per format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instrT;

endpackage

/* rvCore_macros.svh */
// RV32I core parameters
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

`define XLEN      32
`define REG_COUNT 32
`define MEM_AW    8
`define RESET_PC  32'h0000_0000

`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011

`endif
